// ==== image_read_params.svh ====
`ifndef IMAGE_READ_PARAMS_SVH
`define IMAGE_READ_PARAMS_SVH

// config bus
`define IR_CFG_DWIDTH   32
`define IR_CFG_AWIDTH   5

// config register map
`define IR_CFG_IMG_W    5'd0    // image width
`define IR_CFG_IMG_DH   5'd1    // depth and height
`define IR_CFG_PAD      5'd2    // padding on four sides
`define IR_CFG_CONV     5'd3    // conv side and step

// memory side
`define IR_RD_LATENCY   3       // address to data, in cycles
`define IR_GROUP_NB     4       // lanes per word
`define IR_IMG_WIDTH    16      // bits per lane
`define IR_MEM_AWIDTH   16
`define IR_BUF_AWIDTH   4       // 16 deep stall buffer

`endif

// ==== image_read_pkg.sv ====
`default_nettype none

`include "image_read_params.svh"

package image_read_pkg;

    typedef logic [15:0]                               coord_t;     // coordinate or count
    typedef logic [`IR_MEM_AWIDTH-1:0]                 mem_addr_t;
    typedef logic [`IR_GROUP_NB*`IR_IMG_WIDTH-1:0]     pixel_bus_t; // one group word
    typedef logic [`IR_CFG_AWIDTH-1:0]                 cfg_addr_t;

    // one config word, read through the view picked by its address
    typedef union packed {
        logic [`IR_CFG_DWIDTH-1:0] raw;     // image width in the low half
        struct packed {
            coord_t d;
            coord_t h;
        } dh;
        struct packed {
            logic [7:0] l;
            logic [7:0] r;
            logic [7:0] t;
            logic [7:0] b;
        } pad;
        struct packed {
            logic [7:0] rsvd;               // reserved, ignored
            logic [7:0] side;
            coord_t     step;
        } conv;
    } cfg_word_u;

    typedef enum logic [1:0] {
        ST_RESET,
        ST_CONFIG,
        ST_ACTIVE,
        ST_PAUSE
    } scan_state_t;

endpackage

`default_nettype wire

// ==== image_read_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// scan geometry, stable from start until the next config load
interface scan_geom_if;
    import image_read_pkg::*;

    logic   start;      // one cycle pulse
    coord_t area_w;     // padded extents
    coord_t area_h;
    coord_t conv_side;
    coord_t conv_step;
    coord_t img_d;
    coord_t pad_l;
    coord_t pad_t;
    coord_t edge_r;     // last image column, padded space
    coord_t edge_b;     // last image row, padded space
    coord_t plane_wxd;

    modport cfg_mp (output start, area_w, area_h, conv_side, conv_step, img_d,
                    pad_l, pad_t, edge_r, edge_b, plane_wxd);
    modport scan_mp (input start, area_w, area_h, conv_side, conv_step, img_d);
    modport addr_mp (input img_d, pad_l, pad_t, edge_r, edge_b, plane_wxd);
endinterface

// one padded-space pixel per cycle, no back-pressure
interface coord_if;
    import image_read_pkg::*;

    logic   val;
    coord_t x;
    coord_t y;
    coord_t d;
    logic   last;

    modport src_mp (output val, x, y, d, last);
    modport dst_mp (input val, x, y, d, last);
endinterface

`default_nettype wire

// ==== image_read_cfg.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "image_read_params.svh"

module image_read_cfg (
    input  wire                         clk,
    input  wire                         rst,
    input  image_read_pkg::cfg_word_u   cfg_data_i,
    input  image_read_pkg::cfg_addr_t   cfg_addr_i,
    input  wire                         cfg_valid_i,
    input  wire                         next_i,
    scan_geom_if.cfg_mp                 geom
);
    import image_read_pkg::*;

    // staging registers, zero based as written by the host
    coord_t     cfg_img_w;
    coord_t     cfg_img_h;
    coord_t     cfg_img_d;
    logic [7:0] cfg_pad_l;
    logic [7:0] cfg_pad_r;
    logic [7:0] cfg_pad_t;
    logic [7:0] cfg_pad_b;
    logic [7:0] cfg_conv_side;
    coord_t     cfg_conv_step;

    // loaded values, one based
    coord_t img_w, img_h, img_d;
    coord_t pad_l, pad_r, pad_t, pad_b;
    coord_t conv_side, conv_step;

    coord_t area_w, area_h, edge_r, edge_b;
    coord_t plane_part, plane_wxd;

    logic next_1p, next_2p, next_3p;

    always_ff @(posedge clk) begin
        if (cfg_valid_i) begin
            case (cfg_addr_i)
                `IR_CFG_IMG_W: cfg_img_w <= cfg_data_i.raw[15:0];
                `IR_CFG_IMG_DH: begin
                    cfg_img_d <= cfg_data_i.dh.d;
                    cfg_img_h <= cfg_data_i.dh.h;
                end
                `IR_CFG_PAD: begin
                    cfg_pad_l <= cfg_data_i.pad.l;
                    cfg_pad_r <= cfg_data_i.pad.r;
                    cfg_pad_t <= cfg_data_i.pad.t;
                    cfg_pad_b <= cfg_data_i.pad.b;
                end
                `IR_CFG_CONV: begin
                    cfg_conv_side <= cfg_data_i.conv.side;
                    cfg_conv_step <= cfg_data_i.conv.step;
                end
                default: ;      // unmapped address
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            next_1p <= 1'b0;
            next_2p <= 1'b0;
            next_3p <= 1'b0;
        end else begin
            next_1p <= next_i;
            next_2p <= next_1p;
            next_3p <= next_2p;
        end
    end

    always_ff @(posedge clk) begin
        if (next_i) begin
            img_w     <= cfg_img_w + 16'd1;     // 0 means one pixel
            img_h     <= cfg_img_h + 16'd1;
            img_d     <= cfg_img_d + 16'd1;
            pad_l     <= {8'd0, cfg_pad_l};     // 0 means no padding
            pad_r     <= {8'd0, cfg_pad_r};
            pad_t     <= {8'd0, cfg_pad_t};
            pad_b     <= {8'd0, cfg_pad_b};
            conv_side <= {8'd0, cfg_conv_side} + 16'd1;
            conv_step <= cfg_conv_step + 16'd1;
        end
    end

    // derived geometry, settles before start
    always_ff @(posedge clk) begin
        area_w     <= pad_l + img_w + pad_r;
        area_h     <= pad_t + img_h + pad_b;
        edge_r     <= pad_l + img_w - 16'd1;
        edge_b     <= pad_t + img_h - 16'd1;
        plane_part <= img_w * img_d;
        plane_wxd  <= plane_part;   // second multiplier stage
    end

    assign geom.start     = next_3p;
    assign geom.area_w    = area_w;
    assign geom.area_h    = area_h;
    assign geom.conv_side = conv_side;
    assign geom.conv_step = conv_step;
    assign geom.img_d     = img_d;
    assign geom.pad_l     = pad_l;
    assign geom.pad_t     = pad_t;
    assign geom.edge_r    = edge_r;
    assign geom.edge_b    = edge_b;
    assign geom.plane_wxd = plane_wxd;

endmodule

`default_nettype wire

// ==== window_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_scan (
    input  wire         clk,
    input  wire         rst,
    input  wire         image_rdy_i,
    scan_geom_if.scan_mp geom,
    coord_if.src_mp     coord
);
    import image_read_pkg::*;

    scan_state_t state;
    scan_state_t state_nx;

    coord_t cnt_d;      // depth, fastest
    coord_t k_x;        // kernel column
    coord_t k_y;        // kernel row
    coord_t win_x;      // window origin, moves by step
    coord_t win_y;

    logic [16:0] wx_end;    // end of the following window, one extra bit
    logic [16:0] wy_end;
    logic d_last, kx_last, ky_last, wx_last, wy_last;
    logic scan_last;

    assign wx_end    = {1'b0, win_x} + {1'b0, geom.conv_step} + {1'b0, geom.conv_side};
    assign wy_end    = {1'b0, win_y} + {1'b0, geom.conv_step} + {1'b0, geom.conv_side};
    assign d_last    = (cnt_d == geom.img_d - 16'd1);
    assign kx_last   = (k_x == geom.conv_side - 16'd1);
    assign ky_last   = (k_y == geom.conv_side - 16'd1);
    assign wx_last   = (wx_end > {1'b0, geom.area_w});  // next window would not fit
    assign wy_last   = (wy_end > {1'b0, geom.area_h});
    assign scan_last = d_last & kx_last & ky_last & wx_last & wy_last;

    always_comb begin
        state_nx = state;
        case (state)
            ST_RESET:  state_nx = ST_CONFIG;
            ST_CONFIG: if (geom.start) state_nx = image_rdy_i ? ST_ACTIVE : ST_PAUSE;
            ST_ACTIVE: begin
                if (scan_last)         state_nx = ST_RESET;
                else if (!image_rdy_i) state_nx = ST_PAUSE;
            end
            ST_PAUSE:  if (image_rdy_i) state_nx = ST_ACTIVE;
            default:   state_nx = ST_RESET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) state <= ST_RESET;
        else     state <= state_nx;
    end

    always_ff @(posedge clk) begin
        if (rst || state == ST_RESET) begin
            cnt_d <= '0;
            k_x   <= '0;
            k_y   <= '0;
            win_x <= '0;
            win_y <= '0;
        end else if (state == ST_ACTIVE) begin
            cnt_d <= cnt_d + 16'd1;
            if (d_last) begin
                cnt_d <= '0;
                k_x   <= k_x + 16'd1;
                if (kx_last) begin
                    k_x <= '0;
                    k_y <= k_y + 16'd1;
                    if (ky_last) begin
                        k_y   <= '0;
                        win_x <= win_x + geom.conv_step;
                        if (wx_last) begin
                            win_x <= '0;
                            win_y <= wy_last ? '0 : win_y + geom.conv_step;
                        end
                    end
                end
            end
        end
    end

    // pixel in padded space
    assign coord.val  = (state == ST_ACTIVE);
    assign coord.x    = win_x + k_x;
    assign coord.y    = win_y + k_y;
    assign coord.d    = cnt_d;
    assign coord.last = (state == ST_ACTIVE) & scan_last;

    // every emitted pixel lies inside the padded area
    a_coord_range: assert property (@(posedge clk) disable iff (rst)
        coord.val |-> (coord.x < geom.area_w && coord.y < geom.area_h &&
                       coord.d < geom.img_d));

endmodule

`default_nettype wire

// ==== addr_calc.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_calc (
    input  wire                         clk,
    input  wire                         rst,
    scan_geom_if.addr_mp                geom,
    coord_if.dst_mp                     coord,
    output logic                        rd_val_o,
    output image_read_pkg::mem_addr_t   rd_addr_o,
    output logic                        slot_val_o,
    output logic                        slot_pad_o,
    output logic                        slot_last_o
);
    import image_read_pkg::*;

    coord_t    x_1p, y_1p, d_1p;
    mem_addr_t row_2p, col_2p, d_2p;
    mem_addr_t rc_3p, d_3p;
    mem_addr_t addr_4p;

    logic val_1p, val_2p, val_3p;
    logic last_1p, last_2p, last_3p;
    logic pad_2p, pad_3p;

    // flag pipeline, one beat per coordinate
    always_ff @(posedge clk) begin
        if (rst) begin
            val_1p      <= 1'b0;
            val_2p      <= 1'b0;
            val_3p      <= 1'b0;
            last_1p     <= 1'b0;
            last_2p     <= 1'b0;
            last_3p     <= 1'b0;
            pad_2p      <= 1'b0;
            pad_3p      <= 1'b0;
            rd_val_o    <= 1'b0;
            slot_val_o  <= 1'b0;
            slot_pad_o  <= 1'b0;
            slot_last_o <= 1'b0;
        end else begin
            val_1p      <= coord.val;
            last_1p     <= coord.last;
            val_2p      <= val_1p;
            last_2p     <= last_1p;
            pad_2p      <= val_1p & ((x_1p < geom.pad_l) | (x_1p > geom.edge_r) |
                                     (y_1p < geom.pad_t) | (y_1p > geom.edge_b));
            val_3p      <= val_2p;
            last_3p     <= last_2p;
            pad_3p      <= pad_2p;
            rd_val_o    <= val_3p & ~pad_3p;    // padding never reaches memory
            slot_val_o  <= val_3p;
            slot_pad_o  <= pad_3p;
            slot_last_o <= last_3p;
        end
    end

    // (y - pad_t) * W*D + (x - pad_l) * D + d
    always_ff @(posedge clk) begin
        x_1p    <= coord.x;
        y_1p    <= coord.y;
        d_1p    <= coord.d;
        row_2p  <= (y_1p - geom.pad_t) * geom.plane_wxd;
        col_2p  <= (x_1p - geom.pad_l) * geom.img_d;
        d_2p    <= d_1p;
        rc_3p   <= row_2p + col_2p;
        d_3p    <= d_2p;
        addr_4p <= rc_3p + d_3p;
    end

    assign rd_addr_o = addr_4p;

endmodule

`default_nettype wire

// ==== image_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "image_read_params.svh"

module image_buffer (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         slot_val_i,
    input  wire                         slot_pad_i,
    input  wire                         slot_last_i,
    input  image_read_pkg::pixel_bus_t  rd_data_i,
    input  wire                         image_rdy_i,
    output image_read_pkg::pixel_bus_t  image_bus_o,
    output logic                        image_val_o,
    output logic                        image_last_o
);
    import image_read_pkg::*;

    localparam int LAT   = `IR_RD_LATENCY;
    localparam int AW    = `IR_BUF_AWIDTH;
    localparam int DEPTH = 1 << AW;

    logic [LAT-1:0] val_p, pad_p, last_p;  // slot flags waiting on memory

    pixel_bus_t buf_bus;
    logic       buf_val, buf_last;

    pixel_bus_t fifo_bus  [DEPTH];
    logic       fifo_last [DEPTH];
    logic [AW:0] wr_ptr, rd_ptr;        // extra bit tells full from empty
    logic        empty, full, stall, pop;

    pixel_bus_t out_bus;
    logic       out_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            val_p    <= '0;
            pad_p    <= '0;
            last_p   <= '0;
            buf_val  <= 1'b0;
            buf_last <= 1'b0;
        end else begin
            val_p    <= {val_p[LAT-2:0], slot_val_i};
            pad_p    <= {pad_p[LAT-2:0], slot_pad_i};
            last_p   <= {last_p[LAT-2:0], slot_last_i};
            buf_val  <= val_p[LAT-1];
            buf_last <= last_p[LAT-1];
        end
    end

    // memory data lands now, zero word for padding
    always_ff @(posedge clk)
        buf_bus <= pad_p[LAT-1] ? '0 : rd_data_i;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign stall = image_val_o & ~image_rdy_i;
    assign pop   = ~stall & ~empty;

    always_ff @(posedge clk) begin
        if (buf_val) begin
            fifo_bus[wr_ptr[AW-1:0]]  <= buf_bus;
            fifo_last[wr_ptr[AW-1:0]] <= buf_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (buf_val) wr_ptr <= wr_ptr + 1'b1;
            if (pop)     rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // output stage, head of the fifo held while stalled
    always_ff @(posedge clk) begin
        if (rst)         image_val_o <= 1'b0;
        else if (!stall) image_val_o <= ~empty;
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_bus  <= fifo_bus[rd_ptr[AW-1:0]];
            out_last <= fifo_last[rd_ptr[AW-1:0]];
        end
    end

    assign image_bus_o  = out_bus;
    assign image_last_o = image_val_o & out_last;

    // the scan pauses early enough that beats in flight always fit
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        buf_val |-> !full);

    a_bus_hold: assert property (@(posedge clk) disable iff (rst)
        (image_val_o && !image_rdy_i) |=> (image_val_o && $stable(image_bus_o)));

endmodule

`default_nettype wire

// ==== image_read.sv ====
`timescale 1ns/1ps
`default_nettype none

module image_read (
    input  wire                         clk,
    input  wire                         rst,
    input  image_read_pkg::cfg_word_u   cfg_data_i,
    input  image_read_pkg::cfg_addr_t   cfg_addr_i,
    input  wire                         cfg_valid_i,
    input  wire                         next_i,      // load config and start a scan
    output wire                         rd_val_o,
    output image_read_pkg::mem_addr_t   rd_addr_o,
    input  image_read_pkg::pixel_bus_t  rd_data_i,
    output image_read_pkg::pixel_bus_t  image_bus_o,
    output wire                         image_last_o,
    output wire                         image_val_o,
    input  wire                         image_rdy_i
);

    scan_geom_if geom ();
    coord_if     coord ();

    wire slot_val;
    wire slot_pad;
    wire slot_last;

    image_read_cfg u_cfg (
        .clk         (clk),
        .rst         (rst),
        .cfg_data_i  (cfg_data_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_valid_i (cfg_valid_i),
        .next_i      (next_i),
        .geom        (geom.cfg_mp)
    );

    window_scan u_scan (
        .clk         (clk),
        .rst         (rst),
        .image_rdy_i (image_rdy_i),
        .geom        (geom.scan_mp),
        .coord       (coord.src_mp)
    );

    addr_calc u_addr (
        .clk         (clk),
        .rst         (rst),
        .geom        (geom.addr_mp),
        .coord       (coord.dst_mp),
        .rd_val_o    (rd_val_o),
        .rd_addr_o   (rd_addr_o),
        .slot_val_o  (slot_val),
        .slot_pad_o  (slot_pad),
        .slot_last_o (slot_last)
    );

    image_buffer u_buffer (
        .clk          (clk),
        .rst          (rst),
        .slot_val_i   (slot_val),
        .slot_pad_i   (slot_pad),
        .slot_last_i  (slot_last),
        .rd_data_i    (rd_data_i),
        .image_rdy_i  (image_rdy_i),
        .image_bus_o  (image_bus_o),
        .image_val_o  (image_val_o),
        .image_last_o (image_last_o)
    );

endmodule

`default_nettype wire

// ==== tb_image_read.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "image_read_params.svh"

module tb_image_read;
    import image_read_pkg::*;

    logic       clk;
    logic       rst;
    cfg_word_u  cfg_data_i;
    cfg_addr_t  cfg_addr_i;
    logic       cfg_valid_i;
    logic       next_i;
    logic       rd_val_o;
    mem_addr_t  rd_addr_o;
    pixel_bus_t rd_data_i;
    pixel_bus_t image_bus_o;
    logic       image_last_o;
    logic       image_val_o;
    logic       image_rdy_i;

    pixel_bus_t exp_bus[$];     // expected stream, filled before each scan
    logic       exp_last[$];
    int         errors;
    int         beats_seen;
    int         reads_seen;
    logic       last_seen;
    logic       rdy_random;

    mem_addr_t  mem_addr_pipe [`IR_RD_LATENCY-1];
    logic       mem_val_pipe  [`IR_RD_LATENCY-1];

    pixel_bus_t held_bus;
    logic       held_valid;

    image_read dut_i (
        .clk          (clk),
        .rst          (rst),
        .cfg_data_i   (cfg_data_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_valid_i  (cfg_valid_i),
        .next_i       (next_i),
        .rd_val_o     (rd_val_o),
        .rd_addr_o    (rd_addr_o),
        .rd_data_i    (rd_data_i),
        .image_bus_o  (image_bus_o),
        .image_last_o (image_last_o),
        .image_val_o  (image_val_o),
        .image_rdy_i  (image_rdy_i)
    );

    always #10 clk = ~clk;

    // four lanes, each the address plus lane times 4096
    function automatic pixel_bus_t mem_word(input mem_addr_t a);
        pixel_bus_t w;
        w = '0;
        for (int i = 0; i < `IR_GROUP_NB; i++)
            w[i*`IR_IMG_WIDTH +: `IR_IMG_WIDTH] = a + i * 4096;
        return w;
    endfunction

    // window origins while origin + side fits, rows outer, depth fastest inside
    function automatic void ref_stream(input int w, input int h, input int d,
                                       input int pl, input int pr, input int pt,
                                       input int pb, input int side, input int step);
        int aw;
        int ah;
        int x;
        int y;
        aw = pl + w + pr;
        ah = pt + h + pb;
        for (int oy = 0; oy + side <= ah; oy += step)
            for (int ox = 0; ox + side <= aw; ox += step)
                for (int ky = 0; ky < side; ky++)
                    for (int kx = 0; kx < side; kx++)
                        for (int dd = 0; dd < d; dd++) begin
                            x = ox + kx;
                            y = oy + ky;
                            if (x < pl || x >= pl + w || y < pt || y >= pt + h)
                                exp_bus.push_back('0);      // padding pixel
                            else
                                exp_bus.push_back(mem_word(mem_addr_t'((y - pt) * w * d +
                                                                       (x - pl) * d + dd)));
                            exp_last.push_back(1'b0);
                        end
        exp_last[exp_last.size()-1] = 1'b1;
    endfunction

    task automatic check_pixel(input pixel_bus_t got, input pixel_bus_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_last(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: image_last_o got %b expected %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_idle(input logic got, input string what);
        if (got !== 1'b0) begin
            $display("ERR %0t: %s high before any scan", $time, what);
            errors++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("ERR %0t: %s is %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // memory with fixed read latency, filler word when no read was issued
    always @(posedge clk) begin
        if (rd_val_o)
            reads_seen++;
        mem_addr_pipe[0] <= rd_addr_o;
        mem_val_pipe[0]  <= rd_val_o;
        mem_addr_pipe[1] <= mem_addr_pipe[0];
        mem_val_pipe[1]  <= mem_val_pipe[0];
        rd_data_i <= mem_val_pipe[1] ? mem_word(mem_addr_pipe[1]) : {4{16'hbad0}};
    end

    // ready driver, random when asked
    initial begin
        void'($urandom(68163));
        image_rdy_i = 1'b1;
        forever begin
            @(posedge clk);
            if (rdy_random)
                image_rdy_i <= ($urandom % 100) >= 40;
            else
                image_rdy_i <= 1'b1;
        end
    end

    // compare every accepted beat, and the bus under stall
    always @(posedge clk) begin
        if (rst) begin
            held_valid = 1'b0;
        end else begin
            if (held_valid) begin
                if (!image_val_o) begin
                    $display("ERR %0t: image_val_o dropped while stalled", $time);
                    errors++;
                end
                check_pixel(image_bus_o, held_bus, "bus under stall");
            end
            held_valid = image_val_o && !image_rdy_i;
            held_bus   = image_bus_o;
            if (image_val_o && image_rdy_i) begin
                beats_seen++;
                if (exp_bus.size() == 0) begin
                    $display("ERR %0t: beat %h with no expected word left", $time, image_bus_o);
                    errors++;
                end else begin
                    check_pixel(image_bus_o, exp_bus.pop_front(), "image_bus_o");
                    check_last(image_last_o, exp_last.pop_front());
                end
                if (image_last_o)
                    last_seen <= 1'b1;
            end
        end
    end

    task automatic write_cfg(input cfg_addr_t a, input cfg_word_u v);
        @(posedge clk);
        cfg_addr_i  <= a;
        cfg_data_i  <= v;
        cfg_valid_i <= 1'b1;
    endtask

    // writes the four words zero based, pulses next, waits for the last beat
    task automatic run_scan(input int w, input int h, input int d, input int pl,
                            input int pr, input int pt, input int pb, input int side,
                            input int step);
        cfg_word_u v;
        int        n_exp;
        int        n_reads;
        int        cycles;
        n_exp      = exp_bus.size();
        n_reads    = 0;
        // padding beats are the zero words, every other beat is one memory read
        foreach (exp_bus[i]) begin
            if (exp_bus[i] != '0)
                n_reads++;
        end
        beats_seen = 0;
        reads_seen = 0;
        last_seen  = 1'b0;
        v = '0;
        v.raw[15:0] = w - 1;
        write_cfg(`IR_CFG_IMG_W, v);
        v = '0;
        v.dh.d = d - 1;
        v.dh.h = h - 1;
        write_cfg(`IR_CFG_IMG_DH, v);
        v.pad.l = pl;
        v.pad.r = pr;
        v.pad.t = pt;
        v.pad.b = pb;
        write_cfg(`IR_CFG_PAD, v);
        v.conv.rsvd = 8'ha5;        // reserved, must be ignored
        v.conv.side = side - 1;
        v.conv.step = step - 1;
        write_cfg(`IR_CFG_CONV, v);
        @(posedge clk);
        cfg_valid_i <= 1'b0;
        next_i      <= 1'b1;
        @(posedge clk);
        next_i <= 1'b0;
        cycles = 0;
        while (!last_seen && cycles < 5000) begin
            @(posedge clk);
            cycles++;
        end
        if (!last_seen) begin
            $display("timeout: the pixel stream stalled before its last beat");
            $display("errors: %0d", errors + 1);
            $display("Something failed");
            $finish;
        end else begin
            check_count(beats_seen, n_exp, "beats in scan");
            check_count(reads_seen, n_reads, "memory reads in scan");
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        cfg_data_i  = '0;
        cfg_addr_i  = '0;
        cfg_valid_i = 1'b0;
        next_i      = 1'b0;
        rd_data_i   = '0;
        rdy_random  = 1'b0;
        errors      = 0;
        beats_seen  = 0;
        reads_seen  = 0;
        last_seen   = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // idle outputs before the first scan
        repeat (20) begin
            @(posedge clk);
            check_idle(image_val_o, "image_val_o");
            check_idle(rd_val_o, "rd_val_o");
        end

        // 4x4x1, 1x1 conv, words 0..15 in order
        for (int i = 0; i < 16; i++) begin
            exp_bus.push_back(mem_word(mem_addr_t'(i)));
            exp_last.push_back(i == 15);
        end
        run_scan(4, 4, 1, 0, 0, 0, 0, 1, 1);
        repeat (5) @(posedge clk);

        // 5x4x3, pad 1 all round, 3x3 conv
        ref_stream(5, 4, 3, 1, 1, 1, 1, 3, 1);
        run_scan(5, 4, 3, 1, 1, 1, 1, 3, 1);
        repeat (5) @(posedge clk);

        // 6x6x2, 2x2 conv step 2, left 2 and bottom 1
        ref_stream(6, 6, 2, 2, 0, 0, 1, 2, 2);
        check_count(exp_bus.size(), 96, "reference beat count");
        run_scan(6, 6, 2, 2, 0, 0, 1, 2, 2);
        repeat (5) @(posedge clk);

        // same as the padded 3x3 case with random back-pressure
        rdy_random <= 1'b1;
        ref_stream(5, 4, 3, 1, 1, 1, 1, 3, 1);
        run_scan(5, 4, 3, 1, 1, 1, 1, 3, 1);
        rdy_random <= 1'b0;
        repeat (5) @(posedge clk);

        // back to back, next right after each last beat
        ref_stream(6, 6, 2, 2, 0, 0, 1, 2, 2);
        run_scan(6, 6, 2, 2, 0, 0, 1, 2, 2);
        ref_stream(4, 4, 1, 0, 0, 0, 0, 1, 1);
        run_scan(4, 4, 1, 0, 0, 0, 0, 1, 1);
        ref_stream(3, 3, 2, 0, 1, 0, 2, 2, 1);
        run_scan(3, 3, 2, 0, 1, 0, 2, 2, 1);
        repeat (10) @(posedge clk);

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
image_read_pkg.sv
image_read_if.sv
image_read_cfg.sv
window_scan.sv
addr_calc.sv
image_buffer.sv
image_read.sv
tb_image_read.sv
